//--- design/warp_pkg.sv
/*
 * Warp architecture package
 * Sizes of the warp scheduler and the vector types for per-warp state.
 */
`default_nettype none

package warp_pkg;

    localparam int NUM_WARPS   = 4;
    localparam int NUM_THREADS = 4;
    localparam int PC_BITS     = 32;
    localparam int INSTR_BYTES = 4;
    localparam int WID_BITS    = $clog2(NUM_WARPS);

    typedef logic [WID_BITS-1:0]    wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [PC_BITS-1:0]     pc_t;
    typedef logic [NUM_WARPS-1:0]   warp_mask_t;

    // element i belongs to warp i, warp 0 in the low bits
    typedef tmask_t [NUM_WARPS-1:0] tmask_arr_t;
    typedef pc_t    [NUM_WARPS-1:0] pc_arr_t;

endpackage

`default_nettype wire

//--- design/ctr_pkg.sv
/*
 * Counter package
 * Widths of the statistics counters and the pending-instruction count.
 */
`default_nettype none

package ctr_pkg;

    localparam int CTR_BITS  = 32;
    localparam int PEND_BITS = 12;

    typedef logic [CTR_BITS-1:0]  ctr_t;
    typedef logic [PEND_BITS-1:0] pend_t;

endpackage

`default_nettype wire

//--- design/sched_stream_if.sv
/*
 * Schedule stream interface
 * Valid/ready channel that carries one scheduled warp: number, mask and PC.
 */
`default_nettype none

interface sched_stream_if;
    import warp_pkg::*;

    logic   valid;
    logic   ready;
    wid_t   wid;
    tmask_t tmask;
    pc_t    pc;

    modport source  (output valid, output wid, output tmask, output pc, input ready);
    modport sink    (input valid, input wid, input tmask, input pc, output ready);
    modport monitor (input valid, input ready, input wid, input tmask, input pc);

endinterface

`default_nettype wire

//--- design/warp_table.sv
/*
 * Warp state table
 * Holds active, stalled, thread mask and PC of every warp and applies the
 * unlock, TMC, branch, select and issue events each cycle in fixed order.
 */
`default_nettype none

module warp_table #(
    parameter warp_pkg::pc_t START_PC = 32'h8000_0000
) (
    input  wire                  clk,
    input  wire                  reset,

    input  wire                  unlock_valid,
    input  wire warp_pkg::wid_t  unlock_wid,

    input  wire                  tmc_valid,
    input  wire warp_pkg::wid_t  tmc_wid,
    input  wire warp_pkg::tmask_t tmc_tmask,

    input  wire                  branch_valid,
    input  wire warp_pkg::wid_t  branch_wid,
    input  wire                  branch_taken,
    input  wire warp_pkg::pc_t   branch_dest,

    sched_stream_if.monitor      sel,
    sched_stream_if.monitor      issued,

    output warp_pkg::warp_mask_t ready_warps,
    output warp_pkg::tmask_arr_t tmasks,
    output warp_pkg::pc_arr_t    pcs,
    output warp_pkg::warp_mask_t active_warps
);
    import warp_pkg::*;

    warp_mask_t active_q;
    warp_mask_t active_n;
    warp_mask_t stalled_q;
    warp_mask_t stalled_n;
    tmask_arr_t tmask_q;
    tmask_arr_t tmask_n;
    pc_arr_t    pc_q;
    pc_arr_t    pc_n;

    logic sel_fire;
    logic issue_fire;

    assign sel_fire   = sel.valid && sel.ready;
    assign issue_fire = issued.valid && issued.ready;

    // later events override earlier ones for the same warp
    always_comb begin
        active_n  = active_q;
        stalled_n = stalled_q;
        tmask_n   = tmask_q;
        pc_n      = pc_q;

        if (unlock_valid) begin
            stalled_n[unlock_wid] = 1'b0;
        end

        // zero mask parks the warp
        if (tmc_valid) begin
            tmask_n[tmc_wid]   = tmc_tmask;
            active_n[tmc_wid]  = (tmc_tmask != '0);
            stalled_n[tmc_wid] = 1'b0;
        end

        if (branch_valid) begin
            if (branch_taken) begin
                pc_n[branch_wid] = branch_dest;
            end
            stalled_n[branch_wid] = 1'b0;
        end

        // hold the warp until the core answers for it
        if (sel_fire) begin
            stalled_n[sel.wid] = 1'b1;
        end

        if (issue_fire) begin
            pc_n[issued.wid] = issued.pc + pc_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // warp 0 starts single-threaded, everyone else idle
            active_q  <= warp_mask_t'(1);
            stalled_q <= '0;
            tmask_q   <= tmask_arr_t'(1);
            pc_q      <= pc_arr_t'(START_PC);
        end else begin
            active_q  <= active_n;
            stalled_q <= stalled_n;
            tmask_q   <= tmask_n;
            pc_q      <= pc_n;
        end
    end

    assign ready_warps  = active_q & ~stalled_q;
    assign tmasks       = tmask_q;
    assign pcs          = pc_q;
    assign active_warps = active_q;

endmodule

`default_nettype wire

//--- design/warp_select.sv
/*
 * Warp select
 * Picks the lowest-numbered ready warp and presents its mask and PC.
 */
`default_nettype none

module warp_select (
    input  wire warp_pkg::warp_mask_t ready_warps,
    input  wire warp_pkg::tmask_arr_t tmasks,
    input  wire warp_pkg::pc_arr_t    pcs,
    sched_stream_if.source            sel
);
    import warp_pkg::*;

    wid_t pick;

    // scan downward so the lowest set bit wins
    always_comb begin
        pick = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                pick = wid_t'(i);
            end
        end
    end

    assign sel.valid = |ready_warps;
    assign sel.wid   = pick;
    assign sel.tmask = tmasks[pick];
    assign sel.pc    = pcs[pick];

endmodule

`default_nettype wire

//--- design/issue_buffer.sv
/*
 * Issue buffer
 * Two-entry elastic FIFO with a registered output stage on the schedule
 * stream. Cuts the ready path back into selection.
 */
`default_nettype none

module issue_buffer (
    input  wire            clk,
    input  wire            reset,
    sched_stream_if.sink   in_stream,
    sched_stream_if.source out_stream
);
    import warp_pkg::*;

    // head entry drives the output directly
    logic   head_valid;
    wid_t   head_wid;
    tmask_t head_tmask;
    pc_t    head_pc;

    // second entry fills only under back-pressure
    logic   skid_valid;
    wid_t   skid_wid;
    tmask_t skid_tmask;
    pc_t    skid_pc;

    logic push;
    logic pop;

    assign in_stream.ready = !(head_valid && skid_valid);
    assign push = in_stream.valid && in_stream.ready;
    assign pop  = head_valid && out_stream.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            head_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (pop || !head_valid) begin
            if (skid_valid) begin
                head_valid <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                head_valid <= push;
            end
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    // payload follows the same moves without reset
    always_ff @(posedge clk) begin
        if (pop || !head_valid) begin
            if (skid_valid) begin
                head_wid   <= skid_wid;
                head_tmask <= skid_tmask;
                head_pc    <= skid_pc;
            end else begin
                head_wid   <= in_stream.wid;
                head_tmask <= in_stream.tmask;
                head_pc    <= in_stream.pc;
            end
        end else if (push) begin
            skid_wid   <= in_stream.wid;
            skid_tmask <= in_stream.tmask;
            skid_pc    <= in_stream.pc;
        end
    end

    assign out_stream.valid = head_valid;
    assign out_stream.wid   = head_wid;
    assign out_stream.tmask = head_tmask;
    assign out_stream.pc    = head_pc;

endmodule

`default_nettype wire

//--- design/sched_counters.sv
/*
 * Scheduler counters
 * Tracks pending instructions, retired instructions and busy cycles, and
 * registers the busy flag.
 */
`default_nettype none

module sched_counters (
    input  wire                       clk,
    input  wire                       reset,
    sched_stream_if.monitor           issued,
    input  wire                       commit_valid,
    input  wire warp_pkg::warp_mask_t active_warps,
    output ctr_pkg::ctr_t             cycles,
    output ctr_pkg::ctr_t             instret,
    output logic                      busy
);
    import ctr_pkg::*;

    pend_t pending;
    logic  issue_fire;

    assign issue_fire = issued.valid && issued.ready;

    // issue and commit in the same cycle cancel out
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else if (issue_fire && !commit_valid) begin
            pending <= pending + pend_t'(1);
        end else if (!issue_fire && commit_valid) begin
            pending <= pending - pend_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instret <= '0;
            cycles  <= '0;
            busy    <= 1'b0;
        end else begin
            if (commit_valid) begin
                instret <= instret + ctr_t'(1);
            end
            if (busy) begin
                cycles <= cycles + ctr_t'(1);
            end
            busy <= (active_warps != '0) || (pending != '0);
        end
    end

endmodule

`default_nettype wire

//--- design/warp_sched.sv
/*
 * Warp scheduler top level
 * Four-warp SIMT scheduler: warp table, priority select, two-entry issue
 * buffer toward fetch, and the cycle, retire and busy counters.
 */
`default_nettype none

module warp_sched #(
    parameter warp_pkg::pc_t START_PC = 32'h8000_0000
) (
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       unlock_valid,
    input  wire warp_pkg::wid_t       unlock_wid,
    input  wire                       tmc_valid,
    input  wire warp_pkg::wid_t       tmc_wid,
    input  wire warp_pkg::tmask_t     tmc_tmask,
    input  wire                       branch_valid,
    input  wire warp_pkg::wid_t       branch_wid,
    input  wire                       branch_taken,
    input  wire warp_pkg::pc_t        branch_dest,
    input  wire                       commit_valid,

    // fetch side
    output logic                      out_valid,
    input  wire                       out_ready,
    output warp_pkg::wid_t            out_wid,
    output warp_pkg::tmask_t          out_tmask,
    output warp_pkg::pc_t             out_pc,

    output warp_pkg::warp_mask_t      active_warps,
    output ctr_pkg::ctr_t             cycles,
    output ctr_pkg::ctr_t             instret,
    output logic                      busy
);
    warp_pkg::warp_mask_t ready_warps;
    warp_pkg::tmask_arr_t tmasks;
    warp_pkg::pc_arr_t    pcs;

    sched_stream_if sel_stream ();
    sched_stream_if out_stream ();

    warp_table #(
        .START_PC (START_PC)
    ) table_i (
        .clk          (clk),
        .reset        (reset),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .tmc_valid    (tmc_valid),
        .tmc_wid      (tmc_wid),
        .tmc_tmask    (tmc_tmask),
        .branch_valid (branch_valid),
        .branch_wid   (branch_wid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest),
        .sel          (sel_stream),
        .issued       (out_stream),
        .ready_warps  (ready_warps),
        .tmasks       (tmasks),
        .pcs          (pcs),
        .active_warps (active_warps)
    );

    warp_select select_i (
        .ready_warps (ready_warps),
        .tmasks      (tmasks),
        .pcs         (pcs),
        .sel         (sel_stream)
    );

    issue_buffer buffer_i (
        .clk        (clk),
        .reset      (reset),
        .in_stream  (sel_stream),
        .out_stream (out_stream)
    );

    sched_counters counters_i (
        .clk          (clk),
        .reset        (reset),
        .issued       (out_stream),
        .commit_valid (commit_valid),
        .active_warps (active_warps),
        .cycles       (cycles),
        .instret      (instret),
        .busy         (busy)
    );

    assign out_valid        = out_stream.valid;
    assign out_stream.ready = out_ready;
    assign out_wid          = out_stream.wid;
    assign out_tmask        = out_stream.tmask;
    assign out_pc           = out_stream.pc;

endmodule

`default_nettype wire

//--- tb/warp_sched_tb.sv
/*
 * Warp scheduler testbench
 * Random unlock, TMC, branch, commit and back-pressure traffic checked
 * against a per-warp reference model, then a drain that checks the counters.
 */
`default_nettype none

module warp_sched_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import warp_pkg::*;
    import ctr_pkg::*;

    localparam pc_t START_PC    = 32'h8000_0000;
    localparam pc_t PC_STEP     = 32'd4;
    localparam int  NUM_ISSUES  = 400;
    localparam int  TIMEOUT_NS  = NUM_ISSUES * 40 * 8;
    localparam int  WAIT_LIMIT  = 200;
    localparam int  MODE_QUIET  = 0;
    localparam int  MODE_RANDOM = 1;
    localparam int  MODE_DRAIN  = 2;

    logic       clk;
    logic       reset;
    logic       unlock_valid;
    wid_t       unlock_wid;
    logic       tmc_valid;
    wid_t       tmc_wid;
    tmask_t     tmc_tmask;
    logic       branch_valid;
    wid_t       branch_wid;
    logic       branch_taken;
    pc_t        branch_dest;
    logic       commit_valid;
    logic       out_ready;
    logic       out_valid;
    wid_t       out_wid;
    tmask_t     out_tmask;
    pc_t        out_pc;
    warp_mask_t active_warps;
    ctr_t       cycles;
    ctr_t       instret;
    logic       busy;

    // reference model, one entry per warp
    logic [NUM_WARPS-1:0] m_active;
    logic [NUM_WARPS-1:0] m_inflight;
    tmask_t               m_tmask [NUM_WARPS];
    pc_t                  m_pc [NUM_WARPS];
    int                   wait_cycles [NUM_WARPS];

    logic [31:0] rng_state;
    string       test_name;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          issues_seen;
    int          commits_owed;
    int          commits_sent;
    wid_t        last_wid;
    tmask_t      last_tmask;
    pc_t         last_pc;

    always #4 clk = ~clk;

    warp_sched #(
        .START_PC (START_PC)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .unlock_valid (unlock_valid),
        .unlock_wid   (unlock_wid),
        .tmc_valid    (tmc_valid),
        .tmc_wid      (tmc_wid),
        .tmc_tmask    (tmc_tmask),
        .branch_valid (branch_valid),
        .branch_wid   (branch_wid),
        .branch_taken (branch_taken),
        .branch_dest  (branch_dest),
        .commit_valid (commit_valid),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_wid      (out_wid),
        .out_tmask    (out_tmask),
        .out_pc       (out_pc),
        .active_warps (active_warps),
        .cycles       (cycles),
        .instret      (instret),
        .busy         (busy)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s (%s): expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("error in %s: %s", test_name, what);
    endtask

    // an answer frees the warp and owes the core one commit
    task automatic settle(input wid_t w);
        m_inflight[w] = 1'b0;
        commits_owed++;
    endtask

    task automatic update_model();
        if (unlock_valid) begin
            settle(unlock_wid);
        end
        if (tmc_valid) begin
            if (m_inflight[tmc_wid]) begin
                settle(tmc_wid);
            end
            m_tmask[tmc_wid]  = tmc_tmask;
            m_active[tmc_wid] = (tmc_tmask != '0);
        end
        if (branch_valid) begin
            settle(branch_wid);
            if (branch_taken) begin
                m_pc[branch_wid] = branch_dest;
            end
        end
    endtask

    task automatic record_issue();
        issues_seen++;
        last_wid   = out_wid;
        last_tmask = out_tmask;
        last_pc    = out_pc;
        if (!m_active[out_wid]) begin
            note_failure($sformatf("warp %0d issued while inactive", out_wid));
        end
        if (m_inflight[out_wid]) begin
            note_failure($sformatf("warp %0d issued again before an answer", out_wid));
        end
        check_value("issue tmask", 32'(m_tmask[out_wid]), 32'(out_tmask));
        check_value("issue pc", m_pc[out_wid], out_pc);
        m_inflight[out_wid] = 1'b1;
        m_pc[out_wid]       = m_pc[out_wid] + PC_STEP;
    endtask

    // called mid-cycle, while this cycle's inputs and outputs are stable
    task automatic observe();
        wid_t w;
        check_value("active_warps", 32'(m_active), 32'(active_warps));
        if (out_valid && out_ready) begin
            record_issue();
        end
        update_model();
        for (int i = 0; i < NUM_WARPS; i++) begin
            w = wid_t'(i);
            if (m_active[w] && !m_inflight[w]) begin
                wait_cycles[w]++;
                if (wait_cycles[w] == WAIT_LIMIT) begin
                    note_failure($sformatf("ready warp %0d was never issued", w));
                end
            end else begin
                wait_cycles[w] = 0;
            end
        end
    endtask

    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        wid_t        w;
        r = next_rand();
        w = wid_t'(r[5:4]);
        unlock_valid = 1'b0;
        tmc_valid    = 1'b0;
        branch_valid = 1'b0;
        branch_taken = 1'b0;
        commit_valid = 1'b0;
        // roughly 70 percent ready
        out_ready = (mode == MODE_QUIET) || (r[31:24] < 8'd179);
        if (commits_owed > 0 && (mode == MODE_DRAIN || r[8])) begin
            commit_valid = 1'b1;
            commits_owed--;
            commits_sent++;
        end
        if (mode == MODE_RANDOM && m_inflight[w]) begin
            case (r[11:10])
                2'd0: begin
                    unlock_valid = 1'b1;
                    unlock_wid   = w;
                end
                2'd1: begin
                    branch_valid = 1'b1;
                    branch_wid   = w;
                    branch_taken = r[12];
                    branch_dest  = pc_t'(next_rand() & 32'hffff_fffc);
                end
                2'd2: begin
                    tmc_valid = 1'b1;
                    tmc_wid   = w;
                    tmc_tmask = tmask_t'(r[15:12]);
                end
                default: begin
                end
            endcase
        end else if (mode == MODE_RANDOM && !m_active[w] && r[11:10] == 2'd3) begin
            tmc_valid = 1'b1;
            tmc_wid   = w;
            tmc_tmask = tmask_t'(r[15:12]);
        end else if (mode == MODE_DRAIN && m_inflight[w]) begin
            tmc_valid = 1'b1;
            tmc_wid   = w;
            tmc_tmask = '0;
        end
    endtask

    task automatic run_cycle(input int mode);
        @(posedge clk);
        #1;
        drive_inputs(mode);
        @(negedge clk);
        observe();
    endtask

    task automatic end_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    initial begin
        int   start_errors;
        int   guard;
        ctr_t idle_cycles;
        clk          = 1'b0;
        reset        = 1'b1;
        unlock_valid = 1'b0;
        unlock_wid   = '0;
        tmc_valid    = 1'b0;
        tmc_wid      = '0;
        tmc_tmask    = '0;
        branch_valid = 1'b0;
        branch_wid   = '0;
        branch_taken = 1'b0;
        branch_dest  = '0;
        commit_valid = 1'b0;
        out_ready    = 1'b0;
        rng_state    = 32'h8c4a_6cd0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        issues_seen  = 0;
        commits_owed = 0;
        commits_sent = 0;
        m_active     = 4'b0001;
        m_inflight   = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            m_tmask[i]     = '0;
            m_pc[i]        = '0;
            wait_cycles[i] = 0;
        end
        m_tmask[0] = 4'b0001;
        m_pc[0]    = START_PC;

        test_name    = "reset_state";
        start_errors = errors;
        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("out_valid during reset", 32'd0, 32'(out_valid));
        end
        reset = 1'b0;
        guard = 0;
        while (issues_seen == 0 && guard < 10) begin
            run_cycle(MODE_QUIET);
            guard++;
        end
        if (issues_seen == 0) begin
            note_failure("no transfer after reset release");
        end else begin
            check_value("first wid", 32'd0, 32'(last_wid));
            check_value("first tmask", 32'd1, 32'(last_tmask));
            check_value("first pc", START_PC, last_pc);
        end
        check_value("busy after reset", 32'd1, 32'(busy));
        end_test(start_errors);

        test_name    = "random_traffic";
        start_errors = errors;
        while (issues_seen < NUM_ISSUES) begin
            run_cycle(MODE_RANDOM);
        end
        end_test(start_errors);

        // every answer is now a zero-mask TMC until nothing is left
        test_name    = "drain";
        start_errors = errors;
        while (m_active != '0 || m_inflight != '0 || commits_owed != 0) begin
            run_cycle(MODE_DRAIN);
        end
        guard = 0;
        while (busy && guard < 2) begin
            run_cycle(MODE_DRAIN);
            guard++;
        end
        check_value("busy after drain", 32'd0, 32'(busy));
        check_value("instret", 32'(commits_sent), instret);
        idle_cycles = cycles;
        if (idle_cycles == '0) begin
            note_failure("cycle counter never advanced");
        end
        repeat (5) run_cycle(MODE_DRAIN);
        check_value("cycles while idle", idle_cycles, cycles);
        end_test(start_errors);

        $display("tests %0d, failed %0d, checks %0d, errors %0d, issues %0d",
                 tests_run, tests_failed, checks, errors, issues_seen);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // budget of 40 cycles per issue
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: simulation still running after %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/warp_pkg.sv
design/ctr_pkg.sv
design/sched_stream_if.sv
design/warp_table.sv
design/warp_select.sv
design/issue_buffer.sv
design/sched_counters.sv
design/warp_sched.sv
tb/warp_sched_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the warp scheduler testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps -f build.f \
    --top-module warp_sched_tb -Mdir obj_dir -o warp_sched_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/warp_sched_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
